//--- common/pet_ctrl_pkg.sv
package pet_ctrl_pkg;

    // ####################
    // Widths
    // ####################

    localparam int unsigned DATA_WIDTH     = 8;   // Host bus data width.
    localparam int unsigned REG_ADDR_WIDTH = 2;   // Four byte registers.

    // Register map seen by the host.
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        REG_CPU_CTRL    = 2'd0,                   // Read/write.
        REG_SCRATCH     = 2'd1,                   // Read/write.
        REG_STATUS      = 2'd2,                   // Read only.
        REG_RESET_COUNT = 2'd3                    // Read only.
    } reg_addr_e;

    // CPU reset sequencer states.
    typedef enum logic [1:0] {
        SEQ_HELD,                                 // CPU held in reset.
        SEQ_RELEASING,                            // Minimum hold in progress.
        SEQ_RUNNING                               // CPU released.
    } seq_state_e;

    // ####################
    // Register bits
    // ####################

    localparam int unsigned CTRL_RUN_BIT         = 0;
    localparam int unsigned CTRL_FORCE_RESET_BIT = 1;
    localparam logic [DATA_WIDTH-1:0] CTRL_WRITE_MASK = 8'b0000_0011;   // Upper bits read zero.

    localparam int unsigned STATUS_READY_BIT = 0;
    localparam int unsigned STATUS_RESET_BIT = 1;

    // Request handed from capture stage to register access stage.
    typedef struct packed {
        logic                  valid;
        logic                  we;
        reg_addr_e             addr;
        logic [DATA_WIDTH-1:0] wdata;
    } wb_req_t;

    // Response handed from register access stage to response stage.
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] rdata;
    } wb_rsp_t;

endpackage

//--- register_file/wb_request_stage.sv
`timescale 1ns/1ns

module wb_request_stage (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                cycle_i,
    input  logic                                strobe_i,
    input  logic                                we_i,
    input  pet_ctrl_pkg::reg_addr_e             addr_i,
    input  logic [pet_ctrl_pkg::DATA_WIDTH-1:0] data_i,
    output pet_ctrl_pkg::wb_req_t               req_o
);
    import pet_ctrl_pkg::*;

    logic                  accept;
    logic                  valid_q;
    logic                  we_q;
    reg_addr_e             addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    wb_req_t               req_q;

    // A request counts only while the bus cycle is open.
    assign accept = cycle_i & strobe_i;

    // ####################
    // Capture
    // ####################

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;              // One pulse per accepted request.
        end
    end

    // Fields hold their last value between requests.
    always_ff @(posedge clock) begin
        if (accept) begin
            we_q    <= we_i;
            addr_q  <= addr_i;
            wdata_q <= data_i;
        end
    end

    // ####################
    // Request register
    // ####################

    // Hands the request on one edge after acceptance.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            req_q <= '0;
        end else begin
            req_q.valid <= valid_q;
            if (valid_q) begin
                req_q.we    <= we_q;
                req_q.addr  <= addr_q;
                req_q.wdata <= wdata_q;
            end
        end
    end

    assign req_o = req_q;

endmodule

//--- register_file/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                                clock,
    input  logic                                reset_n,
    input  pet_ctrl_pkg::wb_req_t               req_i,
    output pet_ctrl_pkg::wb_rsp_t               rsp_o,
    output logic                                ctrl_run_o,
    output logic                                ctrl_force_reset_o,
    input  logic                                cpu_ready_i,
    input  logic                                cpu_reset_i,
    input  logic [pet_ctrl_pkg::DATA_WIDTH-1:0] release_count_i
);
    import pet_ctrl_pkg::*;

    logic [DATA_WIDTH-1:0] ctrl_q;
    logic [DATA_WIDTH-1:0] scratch_q;
    logic [DATA_WIDTH-1:0] status_value;
    logic [DATA_WIDTH-1:0] read_value;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  rsp_valid_q;
    logic                  write_en;

    assign write_en = req_i.valid & req_i.we;

    // ####################
    // Writable registers
    // ####################

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q    <= '0;
            scratch_q <= '0;
        end else if (write_en) begin
            case (req_i.addr)
                REG_CPU_CTRL: begin
                    ctrl_q <= req_i.wdata & CTRL_WRITE_MASK;   // Only run and force_reset.
                end
                REG_SCRATCH: begin
                    scratch_q <= req_i.wdata;
                end
                default: begin
                    // Status and count ignore writes.
                end
            endcase
        end
    end

    assign ctrl_run_o         = ctrl_q[CTRL_RUN_BIT];
    assign ctrl_force_reset_o = ctrl_q[CTRL_FORCE_RESET_BIT];

    // ####################
    // Read path
    // ####################

    always_comb begin
        status_value                   = '0;
        status_value[STATUS_READY_BIT] = cpu_ready_i;
        status_value[STATUS_RESET_BIT] = cpu_reset_i;
    end

    // Registers as they stand before this edge's write.
    always_comb begin
        case (req_i.addr)
            REG_CPU_CTRL:    read_value = ctrl_q;
            REG_SCRATCH:     read_value = scratch_q;
            REG_STATUS:      read_value = status_value;
            REG_RESET_COUNT: read_value = release_count_i;
            default:         read_value = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;     // One response per request.
        end
    end

    // A write answers with zero data.
    always_ff @(posedge clock) begin
        if (req_i.valid) begin
            rdata_q <= req_i.we ? '0 : read_value;
        end
    end

    assign rsp_o.valid = rsp_valid_q;
    assign rsp_o.rdata = rdata_q;

endmodule

//--- register_file/wb_response_stage.sv
`timescale 1ns/1ns

module wb_response_stage (
    input  logic                                clock,
    input  logic                                reset_n,
    input  pet_ctrl_pkg::wb_rsp_t               rsp_i,
    output logic                                ack_o,
    output logic [pet_ctrl_pkg::DATA_WIDTH-1:0] data_o
);

    // ####################
    // Bus outputs
    // ####################

    // The host bus is shared with other slaves, so data is
    // driven only alongside ack and is zero otherwise.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ack_o  <= 1'b0;
            data_o <= '0;
        end else begin
            ack_o  <= rsp_i.valid;                      // Single-cycle ack.
            data_o <= rsp_i.valid ? rsp_i.rdata : '0;   // No stale data.
        end
    end

endmodule

//--- verilog/cpu_reset_sequencer.sv
`timescale 1ns/1ns

module cpu_reset_sequencer #(
    parameter int unsigned RESET_HOLD_CYCLES = 4
) (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                run_i,
    input  logic                                force_reset_i,
    output logic                                cpu_ready_o,
    output logic                                cpu_reset_o,
    output logic [pet_ctrl_pkg::DATA_WIDTH-1:0] release_count_o
);
    import pet_ctrl_pkg::*;

    localparam int unsigned HOLD_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);
    localparam logic [HOLD_WIDTH-1:0] HOLD_LAST = HOLD_WIDTH'(RESET_HOLD_CYCLES - 1);

    seq_state_e            state_q;
    seq_state_e            state_d;
    logic [HOLD_WIDTH-1:0] hold_count_q;
    logic [DATA_WIDTH-1:0] release_count_q;
    logic                  releasing_done;

    assign releasing_done = (state_q == SEQ_RELEASING) && (state_d == SEQ_RUNNING);

    // ####################
    // Next state
    // ####################

    always_comb begin
        state_d = state_q;
        if (!run_i || force_reset_i) begin
            state_d = SEQ_HELD;                 // Reset request wins from any state.
        end else begin
            case (state_q)
                SEQ_HELD: begin
                    state_d = SEQ_RELEASING;
                end
                SEQ_RELEASING: begin
                    if (hold_count_q == HOLD_LAST) begin
                        state_d = SEQ_RUNNING;  // Minimum hold served.
                    end
                end
                default: begin
                    state_d = SEQ_RUNNING;
                end
            endcase
        end
    end

    // ####################
    // State and counters
    // ####################

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q         <= SEQ_HELD;
            hold_count_q    <= '0;
            release_count_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SEQ_RELEASING) begin
                hold_count_q <= hold_count_q + 1'b1;
            end else begin
                hold_count_q <= '0;             // Restart hold on every entry.
            end
            if (releasing_done) begin
                release_count_q <= release_count_q + 1'b1;   // Wraps at 8 bits.
            end
        end
    end

    assign cpu_ready_o     = (state_q == SEQ_RUNNING);
    assign cpu_reset_o     = ~cpu_ready_o;
    assign release_count_o = release_count_q;

endmodule

//--- verilog/pet_ctrl_top.sv
`timescale 1ns/1ns

module pet_ctrl_top #(
    parameter int unsigned RESET_HOLD_CYCLES = 4
) (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                wb_cycle_i,
    input  logic                                wb_strobe_i,
    input  logic                                wb_we_i,
    input  pet_ctrl_pkg::reg_addr_e             wb_addr_i,
    input  logic [pet_ctrl_pkg::DATA_WIDTH-1:0] wb_data_i,
    output logic [pet_ctrl_pkg::DATA_WIDTH-1:0] wb_data_o,
    output logic                                wb_ack_o,
    output logic                                cpu_ready_o,
    output logic                                cpu_reset_o
);
    import pet_ctrl_pkg::*;

    wb_req_t               req;
    wb_rsp_t               rsp;
    logic                  ctrl_run;
    logic                  ctrl_force_reset;
    logic [DATA_WIDTH-1:0] release_count;

    // ####################
    // Bus pipeline
    // ####################

    wb_request_stage wb_request_stage_inst (
        .clock    (clock),
        .reset_n  (reset_n),
        .cycle_i  (wb_cycle_i),
        .strobe_i (wb_strobe_i),
        .we_i     (wb_we_i),
        .addr_i   (wb_addr_i),
        .data_i   (wb_data_i),
        .req_o    (req)
    );

    register_file register_file_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .req_i              (req),
        .rsp_o              (rsp),
        .ctrl_run_o         (ctrl_run),
        .ctrl_force_reset_o (ctrl_force_reset),
        .cpu_ready_i        (cpu_ready_o),
        .cpu_reset_i        (cpu_reset_o),
        .release_count_i    (release_count)
    );

    wb_response_stage wb_response_stage_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .rsp_i   (rsp),
        .ack_o   (wb_ack_o),
        .data_o  (wb_data_o)
    );

    cpu_reset_sequencer #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) cpu_reset_sequencer_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .run_i           (ctrl_run),
        .force_reset_i   (ctrl_force_reset),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_reset_o     (cpu_reset_o),
        .release_count_o (release_count)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS = 100
) (
    output logic clock_o
);

    // ####################
    // Free running clock
    // ####################

    initial begin
        clock_o = 1'b0;                         // First rising edge at half a period.
    end

    always #(PERIOD_NS / 2) clock_o = ~clock_o;

endmodule

//--- tb/pet_ctrl_props.sv
`timescale 1ns/1ns

module pet_ctrl_props #(
    parameter int unsigned RESET_HOLD_CYCLES = 4
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     cycle_i,
    input  logic                     strobe_i,
    input  logic                     ack_i,
    input  logic                     run_i,
    input  logic                     force_reset_i,
    input  logic                     cpu_ready_i,
    input  logic                     cpu_reset_i,
    input  pet_ctrl_pkg::seq_state_e seq_state_i
);
    import pet_ctrl_pkg::*;

    logic accepted;

    assign accepted = cycle_i & strobe_i;

    // ####################
    // Bus timing
    // ####################

    // Ack is set on the third edge after acceptance, so it is sampled on the fourth.
    ack_after_request: assert property (@(posedge clock) disable iff (!reset_n)
        accepted |-> ##4 ack_i)
        else $error("Accepted request was not acknowledged three edges later.");

    ack_has_request: assert property (@(posedge clock) disable iff (!reset_n)
        ack_i |-> $past(accepted, 4))
        else $error("Ack seen without a matching request.");

    // ####################
    // CPU lines
    // ####################

    // A reset request puts the CPU into reset on the next edge.
    reset_request_lands: assert property (@(posedge clock) disable iff (!reset_n)
        (!run_i || force_reset_i) |=> (cpu_reset_i && !cpu_ready_i))
        else $error("CPU lines did not enter reset one edge after a reset request.");

    // Ready rises only on the step out of a full hold in the releasing state.
    ready_after_hold: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(cpu_ready_i) |-> ($past(seq_state_i) == SEQ_RELEASING)
                               && $past(seq_state_i == SEQ_RELEASING, RESET_HOLD_CYCLES))
        else $error("CPU ready rose without a full hold in the releasing state.");

endmodule

bind pet_ctrl_top pet_ctrl_props #(
    .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
) pet_ctrl_props_inst (
    .clock         (clock),
    .reset_n       (reset_n),
    .cycle_i       (wb_cycle_i),
    .strobe_i      (wb_strobe_i),
    .ack_i         (wb_ack_o),
    .run_i         (ctrl_run),
    .force_reset_i (ctrl_force_reset),
    .cpu_ready_i   (cpu_ready_o),
    .cpu_reset_i   (cpu_reset_o),
    .seq_state_i   (cpu_reset_sequencer_inst.state_q)
);

//--- tb/pet_ctrl_tb.sv
`timescale 1ns/1ns

module pet_ctrl_tb;
    import pet_ctrl_pkg::*;

    localparam int unsigned RESET_HOLD_CYCLES = 4;
    localparam int unsigned ACK_DELAY         = 4;    // Falling edges from drive to ack.
    localparam int unsigned BATCH_TIMEOUT     = 16;
    localparam string       TRACE_FILE        = "tb/pet_ctrl_trace.txt";

    logic                  clock;
    logic                  reset_n;
    logic                  wb_cycle;
    logic                  wb_strobe;
    logic                  wb_we;
    reg_addr_e             wb_addr;
    logic [DATA_WIDTH-1:0] wb_data_in;
    logic [DATA_WIDTH-1:0] wb_data_out;
    logic                  wb_ack;
    logic                  cpu_ready;
    logic                  cpu_reset;

    // Parsed trace lines.
    byte                   op_q[$];
    reg_addr_e             addr_q[$];
    logic [DATA_WIDTH-1:0] data_q[$];
    int unsigned           wait_q[$];

    // Requests of the burst being run.
    logic                  batch_we[$];
    reg_addr_e             batch_addr[$];
    logic [DATA_WIDTH-1:0] batch_data[$];

    tb_clock_gen #(.PERIOD_NS(100)) tb_clock_gen_inst (.clock_o(clock));

    pet_ctrl_top #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) pet_ctrl_top_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .wb_cycle_i  (wb_cycle),
        .wb_strobe_i (wb_strobe),
        .wb_we_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data_in),
        .wb_data_o   (wb_data_out),
        .wb_ack_o    (wb_ack),
        .cpu_ready_o (cpu_ready),
        .cpu_reset_o (cpu_reset)
    );

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    // ####################
    // Bus driving
    // ####################

    task automatic drive_request(input logic we, input reg_addr_e addr,
                                 input logic [DATA_WIDTH-1:0] data);
        wb_cycle   = 1'b1;
        wb_strobe  = 1'b1;
        wb_we      = we;
        wb_addr    = addr;
        wb_data_in = data;
    endtask

    task automatic release_bus();
        wb_cycle   = 1'b0;
        wb_strobe  = 1'b0;
        wb_we      = 1'b0;
        wb_data_in = '0;
    endtask

    // Issues the queued requests on consecutive cycles and collects the acks in order.
    task automatic run_batch(input bit check_ack_end);
        int unsigned           issue_tick[$];
        int unsigned           total;
        int unsigned           issued;
        int unsigned           acked;
        int unsigned           tick;
        logic [DATA_WIDTH-1:0] expected;
        total  = batch_we.size();
        issued = 0;
        acked  = 0;
        tick   = 0;
        while (acked < total) begin
            @(negedge clock);
            tick++;
            assert (tick <= total + BATCH_TIMEOUT) else begin
                $display("Timeout waiting for ack %0d of %0d", acked + 1, total);
                stop_run();
            end
            if (wb_ack) begin
                assert (acked < issued) else begin
                    $display("Ack seen at %0t ns with no request outstanding", $time);
                    stop_run();
                end
                assert (tick - issue_tick[acked] == ACK_DELAY) else begin
                    $display("Ack %0d arrived %0d cycles after its request", acked,
                             tick - issue_tick[acked]);
                    stop_run();
                end
                expected = batch_we[acked] ? '0 : batch_data[acked];   // Writes answer zero.
                assert (wb_data_out == expected) else begin
                    $display("MISMATCH at %0t ns: wb_data_o expected %02h got %02h",
                             $time, expected, wb_data_out);
                    stop_run();
                end
                acked++;
            end
            if (issued < total) begin
                drive_request(batch_we[issued], batch_addr[issued],
                              batch_we[issued] ? batch_data[issued] : '0);
                issue_tick.push_back(tick);
                issued++;
            end else begin
                release_bus();
            end
        end
        if (check_ack_end) begin
            @(negedge clock);
            assert (!wb_ack) else begin
                $display("MISMATCH at %0t ns: wb_ack_o expected 0 got 1", $time);
                stop_run();
            end
        end
        batch_we.delete();
        batch_addr.delete();
        batch_data.delete();
    endtask

    // ####################
    // CPU lines
    // ####################

    // Expected value uses the status layout {cpu_reset, cpu_ready}.
    task automatic check_cpu_lines(input logic [1:0] expected, input int unsigned max_wait);
        int unsigned waited;
        logic        was_ready;
        logic [1:0]  seen;
        waited    = 0;
        was_ready = cpu_ready;
        seen      = {cpu_reset, cpu_ready};
        while (seen != expected && waited < max_wait) begin
            @(negedge clock);
            waited++;
            seen = {cpu_reset, cpu_ready};
        end
        assert (seen == expected) else begin
            $display("MISMATCH at %0t ns: {cpu_reset_o, cpu_ready_o} expected %b got %b",
                     $time, expected, seen);
            stop_run();
        end
        if (!was_ready && expected[0]) begin
            assert (waited >= RESET_HOLD_CYCLES) else begin
                $display("CPU released after %0d cycles, before the minimum hold of %0d",
                         waited, RESET_HOLD_CYCLES);
                stop_run();
            end
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          fields;
        string       line;
        byte         op;
        int unsigned addr;
        int unsigned data;
        int unsigned wait_max;
        fd = $fopen(TRACE_FILE, "r");
        assert (fd != 0) else begin
            $display("Could not open trace file %s", TRACE_FILE);
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;                       // Blank or comment line.
            end
            fields = $sscanf(line, "%c %h %h %d", op, addr, data, wait_max);
            assert (fields == 4) else begin
                $display("Trace line could not be parsed: %s", line);
                stop_run();
            end
            op_q.push_back(op);
            addr_q.push_back(reg_addr_e'(addr[REG_ADDR_WIDTH-1:0]));
            data_q.push_back(data[DATA_WIDTH-1:0]);
            wait_q.push_back(wait_max);
        end
        $fclose(fd);
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin
        int unsigned idx;
        reset_n    = 1'b0;
        wb_cycle   = 1'b0;
        wb_strobe  = 1'b0;
        wb_we      = 1'b0;
        wb_addr    = REG_CPU_CTRL;
        wb_data_in = '0;
        load_trace();
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        idx     = 0;
        while (idx < op_q.size()) begin
            case (op_q[idx])
                "W", "R": begin
                    batch_we.push_back(op_q[idx] == "W");
                    batch_addr.push_back(addr_q[idx]);
                    batch_data.push_back(data_q[idx]);
                    idx++;
                    run_batch(1'b0);
                end
                "P": begin
                    while (idx < op_q.size() && op_q[idx] == "P") begin
                        batch_we.push_back(1'b0);
                        batch_addr.push_back(addr_q[idx]);
                        batch_data.push_back(data_q[idx]);
                        idx++;
                    end
                    run_batch(1'b1);            // Back-to-back reads.
                end
                "C": begin
                    check_cpu_lines(data_q[idx][1:0], wait_q[idx]);
                    idx++;
                end
                default: begin
                    $display("Unknown trace operation %c on entry %0d", op_q[idx], idx);
                    stop_run();
                end
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb/pet_ctrl_trace.txt
# op addr data wait  (op W write, R read expecting data, P back-to-back read, C CPU lines)
# C data is {cpu_reset, cpu_ready} and wait is the longest poll in cycles, all hex but wait
C 2 02 4
R 0 00 0
R 1 00 0
R 2 02 0
R 3 00 0
W 0 01 0
C 2 01 6
R 2 01 0
R 3 01 0
R 0 01 0
W 0 03 0
C 2 02 2
R 0 03 0
R 2 02 0
W 0 01 0
C 2 01 6
R 3 02 0
W 0 00 0
C 2 02 2
R 0 00 0
W 0 ff 0
C 2 02 2
R 0 03 0
W 1 a5 0
R 1 a5 0
W 1 5a 0
W 2 ff 0
W 3 ff 0
P 0 03 0
P 1 5a 0
P 2 02 0
P 3 02 0

//--- pet_ctrl.f
common/pet_ctrl_pkg.sv
register_file/wb_request_stage.sv
register_file/register_file.sv
register_file/wb_response_stage.sv
verilog/cpu_reset_sequencer.sv
verilog/pet_ctrl_top.sv
tb/tb_clock_gen.sv
tb/pet_ctrl_props.sv
tb/pet_ctrl_tb.sv
